// ==== sim/fft_stage_golden.txt ====
// One block per line, 32 hex words: lanes 0-3 as a_re a_im b_re b_im,
// then lanes 0-3 as add_re add_im diff_re diff_im
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000080 000080 000080 FFFF80 00008C 000072 000072 FFFF74 000097 000065 000065 FFFF69 00009F 000055 000055 FFFF61
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 0000A7 000045 000045 FFFF59 0000AD 000035 000035 FFFF53 0000B1 000023 000023 FFFF4F 0000B4 000012 000012 FFFF4C
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 0000B6 000000 000000 FFFF4A 0000B4 FFFFEE FFFFEE FFFF4C 0000B1 FFFFDD FFFFDD FFFF4F 0000AD FFFFCB FFFFCB FFFF53
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 0000A7 FFFFBB FFFFBB FFFF59 00009F FFFFAB FFFFAB FFFF61 000097 FFFF9B FFFF9B FFFF69 00008C FFFF8E FFFF8E FFFF74
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000080 FFFF80 FFFF80 FFFF80 000072 FFFF74 FFFF74 FFFF8E 000065 FFFF69 FFFF69 FFFF9B 000055 FFFF61 FFFF61 FFFFAB
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000045 FFFF59 FFFF59 FFFFBB 000035 FFFF53 FFFF53 FFFFCB 000023 FFFF4F FFFF4F FFFFDD 000012 FFFF4C FFFF4C FFFFEE
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000000 FFFF4A FFFF4A 000000 FFFFEE FFFF4C FFFF4C 000012 FFFFDD FFFF4F FFFF4F 000023 FFFFCB FFFF53 FFFF53 000035
000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 000001 000000 000000 000001 FFFFBB FFFF59 FFFF59 000045 FFFFAB FFFF61 FFFF61 000055 FFFF9B FFFF69 FFFF69 000065 FFFF8E FFFF74 FFFF74 000072
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFF00 000100 FFFF00 FFFF00 FFFF1C 000118 FFFEE8 FFFF1C FFFF36 00012E FFFED2 FFFF36 FFFF56 00013E FFFEC2 FFFF56
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFF76 00014E FFFEB2 FFFF76 FFFF96 00015A FFFEA6 FFFF96 FFFFBA 000162 FFFE9E FFFFBA FFFFDC 000168 FFFE98 FFFFDC
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 000000 00016C FFFE94 000000 000024 000168 FFFE98 000024 000046 000162 FFFE9E 000046 00006A 00015A FFFEA6 00006A
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 00008A 00014E FFFEB2 00008A 0000AA 00013E FFFEC2 0000AA 0000CA 00012E FFFED2 0000CA 0000E4 000118 FFFEE8 0000E4
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 000100 000100 FFFF00 000100 000118 0000E4 FFFF1C 000118 00012E 0000CA FFFF36 00012E 00013E 0000AA FFFF56 00013E
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 00014E 00008A FFFF76 00014E 00015A 00006A FFFF96 00015A 000162 000046 FFFFBA 000162 000168 000024 FFFFDC 000168
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 00016C 000000 000000 00016C 000168 FFFFDC 000024 000168 000162 FFFFBA 000046 000162 00015A FFFF96 00006A 00015A
FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 FFFFFE 000000 000000 000002 00014E FFFF76 00008A 00014E 00013E FFFF56 0000AA 00013E 00012E FFFF36 0000CA 00012E 000118 FFFF1C 0000E4 000118

// ==== vlog.f ====
source/fft_pkg.sv
source/bfly_if.sv
source/twiddle_rom.sv
source/twiddle_mul.sv
source/butterfly_stage.sv
source/input_credit_buffer.sv
source/output_credit_queue.sv
source/fft_stage_top.sv
sim/tb_fft_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FFT stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_fft_stage -f vlog.f -o sim_fft \
    && ./obj_dir/sim_fft > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "^Result: PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/tb_fft_stage.sv ====
module tb_fft_stage;

    localparam int NUM_BLOCKS = 16;
    localparam int WORDS      = 32;
    localparam int MAX_CYCLES = NUM_BLOCKS * 40 + 200;

    logic             clk;
    logic             rstn;
    logic             in_valid;
    fft_pkg::sample_t in_a_re [fft_pkg::LANES];
    fft_pkg::sample_t in_a_im [fft_pkg::LANES];
    fft_pkg::sample_t in_b_re [fft_pkg::LANES];
    fft_pkg::sample_t in_b_im [fft_pkg::LANES];
    logic             out_credit;
    logic             in_credit;
    logic             out_valid;
    fft_pkg::prod_t   out_add_re  [fft_pkg::LANES];
    fft_pkg::prod_t   out_add_im  [fft_pkg::LANES];
    fft_pkg::prod_t   out_diff_re [fft_pkg::LANES];
    fft_pkg::prod_t   out_diff_im [fft_pkg::LANES];

    logic [23:0] golden [NUM_BLOCKS * WORDS];
    int seed            = 85751;
    int value_errors    = 0;
    int proto_errors    = 0;
    int sent            = 0;
    int received        = 0;
    int out_pulses      = 0;
    int in_credits_seen = 0;
    int granted         = 0;
    int cycles          = 0;

    fft_stage_top dut (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_a_re     (in_a_re),
        .in_a_im     (in_a_im),
        .in_b_re     (in_b_re),
        .in_b_im     (in_b_im),
        .out_credit  (out_credit),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_add_re  (out_add_re),
        .out_add_im  (out_add_im),
        .out_diff_re (out_diff_re),
        .out_diff_im (out_diff_im)
    );

    task automatic check_prod(input string name, input fft_pkg::prod_t exp,
                              input fft_pkg::prod_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // Expected words follow the 16 input words of a line
    task automatic check_block(input int blk);
        int base;
        base = blk * WORDS + 16;
        for (int l = 0; l < fft_pkg::LANES; l++) begin
            check_prod($sformatf("out_add_re[%0d] blk %0d", l, blk),
                       golden[base + l * 4][22:0], out_add_re[l]);
            check_prod($sformatf("out_add_im[%0d] blk %0d", l, blk),
                       golden[base + l * 4 + 1][22:0], out_add_im[l]);
            check_prod($sformatf("out_diff_re[%0d] blk %0d", l, blk),
                       golden[base + l * 4 + 2][22:0], out_diff_re[l]);
            check_prod($sformatf("out_diff_im[%0d] blk %0d", l, blk),
                       golden[base + l * 4 + 3][22:0], out_diff_im[l]);
        end
    endtask

    task automatic drive_block(input int blk);
        int base;
        base = blk * WORDS;
        in_valid = 1'b1;
        for (int l = 0; l < fft_pkg::LANES; l++) begin
            in_a_re[l] = golden[base + l * 4][12:0];
            in_a_im[l] = golden[base + l * 4 + 1][12:0];
            in_b_re[l] = golden[base + l * 4 + 2][12:0];
            in_b_im[l] = golden[base + l * 4 + 3][12:0];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d blocks came out", received, NUM_BLOCKS);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (sent == 0 && (in_credit || out_valid)) begin
                proto_errors++;
                $display("DUT raised in_credit or out_valid before any input at %0t", $time);
            end
            if (in_credit) begin
                in_credits_seen++;
            end
            if (out_valid) begin
                out_pulses++;
                if (received >= NUM_BLOCKS) begin
                    proto_errors++;
                    $display("DUT sent an extra output block at %0t", $time);
                end else begin
                    check_block(received);
                    received++;
                end
                if (out_pulses > granted) begin
                    proto_errors++;
                    $display("out_valid without a granted credit at %0t", $time);
                end
            end
            if (out_credit) begin
                granted++;
            end
        end
    end

    // Random grants with two long stretches of back-pressure
    initial begin
        int r;
        int gen_cyc;
        int late_stall;
        out_credit = 1'b0;
        gen_cyc = 0;
        late_stall = 0;
        wait (rstn);
        forever begin
            @(posedge clk);
            #2;
            gen_cyc++;
            r = $random(seed);
            if (gen_cyc >= 5 && gen_cyc < 25) begin
                out_credit = 1'b0;
            end else if (received >= NUM_BLOCKS / 2 && late_stall < 20) begin
                // Second stretch once half the blocks are out
                late_stall++;
                out_credit = 1'b0;
            end else begin
                out_credit = ((r & 1) == 1);
            end
        end
    end

    initial begin
        rstn     = 1'b0;
        in_valid = 1'b0;
        for (int l = 0; l < fft_pkg::LANES; l++) begin
            in_a_re[l] = '0;
            in_a_im[l] = '0;
            in_b_re[l] = '0;
            in_b_im[l] = '0;
        end
        $readmemh("sim/fft_stage_golden.txt", golden);
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;
        repeat (4) @(posedge clk);
        // Upstream holds IN_DEPTH credits at the start
        while (sent < NUM_BLOCKS) begin
            @(posedge clk);
            #2;
            if (sent - in_credits_seen < fft_pkg::IN_DEPTH) begin
                drive_block(sent);
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        while (received < NUM_BLOCKS) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        check_count("in_credit pulses", NUM_BLOCKS, in_credits_seen);
        check_count("out_valid pulses", NUM_BLOCKS, out_pulses);
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== source/fft_stage_top.sv ====
module fft_stage_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  fft_pkg::sample_t in_a_re [fft_pkg::LANES],
    input  fft_pkg::sample_t in_a_im [fft_pkg::LANES],
    input  fft_pkg::sample_t in_b_re [fft_pkg::LANES],
    input  fft_pkg::sample_t in_b_im [fft_pkg::LANES],
    input  logic             out_credit,
    output logic             in_credit,
    output logic             out_valid,
    output fft_pkg::prod_t   out_add_re  [fft_pkg::LANES],
    output fft_pkg::prod_t   out_add_im  [fft_pkg::LANES],
    output fft_pkg::prod_t   out_diff_re [fft_pkg::LANES],
    output fft_pkg::prod_t   out_diff_im [fft_pkg::LANES]
);

    pair_if pair_bus ();
    res_if  res_bus ();
    logic   slot_free;

    input_credit_buffer u_in_buf (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_a_re   (in_a_re),
        .in_a_im   (in_a_im),
        .in_b_re   (in_b_re),
        .in_b_im   (in_b_im),
        .in_credit (in_credit),
        .slot_free (slot_free),
        .pair      (pair_bus.src)
    );

    butterfly_stage u_bfly (
        .clk  (clk),
        .rstn (rstn),
        .pair (pair_bus.snk),
        .res  (res_bus.src)
    );

    // Returns one slot credit per block sent downstream
    output_credit_queue u_out_q (
        .clk         (clk),
        .rstn        (rstn),
        .res         (res_bus.snk),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_add_re  (out_add_re),
        .out_add_im  (out_add_im),
        .out_diff_re (out_diff_re),
        .out_diff_im (out_diff_im),
        .slot_free   (slot_free)
    );

endmodule

// ==== source/output_credit_queue.sv ====
module output_credit_queue (
    input  logic           clk,
    input  logic           rstn,
    res_if.snk             res,
    input  logic           out_credit,
    output logic           out_valid,
    output fft_pkg::prod_t out_add_re  [fft_pkg::LANES],
    output fft_pkg::prod_t out_add_im  [fft_pkg::LANES],
    output fft_pkg::prod_t out_diff_re [fft_pkg::LANES],
    output fft_pkg::prod_t out_diff_im [fft_pkg::LANES],
    output logic           slot_free
);

    fft_pkg::prod_t           mem_add_re  [fft_pkg::OUT_DEPTH][fft_pkg::LANES];
    fft_pkg::prod_t           mem_add_im  [fft_pkg::OUT_DEPTH][fft_pkg::LANES];
    fft_pkg::prod_t           mem_diff_re [fft_pkg::OUT_DEPTH][fft_pkg::LANES];
    fft_pkg::prod_t           mem_diff_im [fft_pkg::OUT_DEPTH][fft_pkg::LANES];
    logic [fft_pkg::OUT_PW-1:0] wr_ptr;
    logic [fft_pkg::OUT_PW-1:0] rd_ptr;
    logic [fft_pkg::OUT_PW:0]   count;
    fft_pkg::credit_cnt_t       credit_cnt;
    logic                       send;

    // Head leaves only against a downstream credit
    assign send = (count != '0) && (credit_cnt != '0);

    assign out_valid   = send;
    assign out_add_re  = mem_add_re[rd_ptr];
    assign out_add_im  = mem_add_im[rd_ptr];
    assign out_diff_re = mem_diff_re[rd_ptr];
    assign out_diff_im = mem_diff_im[rd_ptr];

    // Slot goes back to the input side
    assign slot_free = send;

    always_ff @(posedge clk) begin
        if (res.valid) begin
            mem_add_re[wr_ptr]  <= res.add_re;
            mem_add_im[wr_ptr]  <= res.add_im;
            mem_diff_re[wr_ptr] <= res.diff_re;
            mem_diff_im[wr_ptr] <= res.diff_im;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= '0;
        end else begin
            if (res.valid) begin
                wr_ptr <= (int'(wr_ptr) == fft_pkg::OUT_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (int'(rd_ptr) == fft_pkg::OUT_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({res.valid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Credit count saturates at its maximum
            case ({out_credit, send})
                2'b10:   credit_cnt <= (credit_cnt == '1) ? credit_cnt : credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== source/input_credit_buffer.sv ====
module input_credit_buffer (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  fft_pkg::sample_t in_a_re [fft_pkg::LANES],
    input  fft_pkg::sample_t in_a_im [fft_pkg::LANES],
    input  fft_pkg::sample_t in_b_re [fft_pkg::LANES],
    input  fft_pkg::sample_t in_b_im [fft_pkg::LANES],
    output logic             in_credit,
    input  logic             slot_free,
    pair_if.src              pair
);

    fft_pkg::sample_t        mem_a_re [fft_pkg::IN_DEPTH][fft_pkg::LANES];
    fft_pkg::sample_t        mem_a_im [fft_pkg::IN_DEPTH][fft_pkg::LANES];
    fft_pkg::sample_t        mem_b_re [fft_pkg::IN_DEPTH][fft_pkg::LANES];
    fft_pkg::sample_t        mem_b_im [fft_pkg::IN_DEPTH][fft_pkg::LANES];
    logic [fft_pkg::IN_PW-1:0] wr_ptr;
    logic [fft_pkg::IN_PW-1:0] rd_ptr;
    logic [fft_pkg::IN_PW:0]   count;
    fft_pkg::credit_cnt_t      slot_cnt;
    logic                      pop;

    // Issue needs a queued block and a free slot in the result queue
    assign pop = (count != '0) && (slot_cnt != '0);

    assign pair.valid = pop;
    assign pair.a_re  = mem_a_re[rd_ptr];
    assign pair.a_im  = mem_a_im[rd_ptr];
    assign pair.b_re  = mem_b_re[rd_ptr];
    assign pair.b_im  = mem_b_im[rd_ptr];

    // Each pop frees one upstream entry
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem_a_re[wr_ptr] <= in_a_re;
            mem_a_im[wr_ptr] <= in_a_im;
            mem_b_re[wr_ptr] <= in_b_re;
            mem_b_im[wr_ptr] <= in_b_im;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            slot_cnt <= fft_pkg::credit_cnt_t'(fft_pkg::OUT_DEPTH);
        end else begin
            if (in_valid) begin
                wr_ptr <= (int'(wr_ptr) == fft_pkg::IN_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == fft_pkg::IN_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({slot_free, pop})
                2'b10:   slot_cnt <= slot_cnt + 1'b1;
                2'b01:   slot_cnt <= slot_cnt - 1'b1;
                default: slot_cnt <= slot_cnt;
            endcase
        end
    end

endmodule

// ==== source/butterfly_stage.sv ====
module butterfly_stage (
    input logic clk,
    input logic rstn,
    pair_if.snk pair,
    res_if.src  res
);

    fft_pkg::bsum_t    sum_re  [fft_pkg::LANES];
    fft_pkg::bsum_t    sum_im  [fft_pkg::LANES];
    fft_pkg::bsum_t    dif_re  [fft_pkg::LANES];
    fft_pkg::bsum_t    dif_im  [fft_pkg::LANES];
    fft_pkg::twf_t     tw_re   [fft_pkg::LANES];
    fft_pkg::twf_t     tw_im   [fft_pkg::LANES];
    fft_pkg::prod_t    add_re_p  [fft_pkg::LANES];
    fft_pkg::prod_t    add_im_p  [fft_pkg::LANES];
    fft_pkg::prod_t    diff_re_p [fft_pkg::LANES];
    fft_pkg::prod_t    diff_im_p [fft_pkg::LANES];
    fft_pkg::blk_idx_t blk_idx;
    logic              valid_d1;

    // ROM output lines up with the sum/diff register
    twiddle_rom u_rom (
        .clk   (clk),
        .rstn  (rstn),
        .blk   (blk_idx),
        .tw_re (tw_re),
        .tw_im (tw_im)
    );

    twiddle_mul u_mul_add (
        .d_re (sum_re),
        .d_im (sum_im),
        .w_re (tw_re),
        .w_im (tw_im),
        .p_re (add_re_p),
        .p_im (add_im_p)
    );

    twiddle_mul u_mul_diff (
        .d_re (dif_re),
        .d_im (dif_im),
        .w_re (tw_re),
        .w_im (tw_im),
        .p_re (diff_re_p),
        .p_im (diff_im_p)
    );

    // Block counter steps once per accepted block
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blk_idx  <= '0;
            valid_d1 <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            valid_d1  <= pair.valid;
            res.valid <= valid_d1;
            if (pair.valid) begin
                blk_idx <= (int'(blk_idx) == fft_pkg::BLOCKS - 1) ? '0 : blk_idx + 1'b1;
            end
        end
    end

    // Cycle 1
    always_ff @(posedge clk) begin
        if (pair.valid) begin
            for (int i = 0; i < fft_pkg::LANES; i++) begin
                sum_re[i] <= fft_pkg::bsum_t'(pair.a_re[i]) + fft_pkg::bsum_t'(pair.b_re[i]);
                sum_im[i] <= fft_pkg::bsum_t'(pair.a_im[i]) + fft_pkg::bsum_t'(pair.b_im[i]);
                dif_re[i] <= fft_pkg::bsum_t'(pair.a_re[i]) - fft_pkg::bsum_t'(pair.b_re[i]);
                dif_im[i] <= fft_pkg::bsum_t'(pair.a_im[i]) - fft_pkg::bsum_t'(pair.b_im[i]);
            end
        end
    end

    // Cycle 2
    always_ff @(posedge clk) begin
        if (valid_d1) begin
            for (int i = 0; i < fft_pkg::LANES; i++) begin
                res.add_re[i]  <= add_re_p[i];
                res.add_im[i]  <= add_im_p[i];
                res.diff_re[i] <= diff_re_p[i];
                res.diff_im[i] <= diff_im_p[i];
            end
        end
    end

endmodule

// ==== source/twiddle_mul.sv ====
module twiddle_mul (
    input  fft_pkg::bsum_t d_re [fft_pkg::LANES],
    input  fft_pkg::bsum_t d_im [fft_pkg::LANES],
    input  fft_pkg::twf_t  w_re [fft_pkg::LANES],
    input  fft_pkg::twf_t  w_im [fft_pkg::LANES],
    output fft_pkg::prod_t p_re [fft_pkg::LANES],
    output fft_pkg::prod_t p_im [fft_pkg::LANES]
);

    // Operands widened to product width before multiply
    always_comb begin
        for (int i = 0; i < fft_pkg::LANES; i++) begin
            p_re[i] = fft_pkg::prod_t'(d_re[i]) * fft_pkg::prod_t'(w_re[i])
                    - fft_pkg::prod_t'(d_im[i]) * fft_pkg::prod_t'(w_im[i]);
            p_im[i] = fft_pkg::prod_t'(d_re[i]) * fft_pkg::prod_t'(w_im[i])
                    + fft_pkg::prod_t'(d_im[i]) * fft_pkg::prod_t'(w_re[i]);
        end
    end

endmodule

// ==== source/twiddle_rom.sv ====
module twiddle_rom (
    input  logic              clk,
    input  logic              rstn,
    input  fft_pkg::blk_idx_t blk,
    output fft_pkg::twf_t     tw_re [fft_pkg::LANES],
    output fft_pkg::twf_t     tw_im [fft_pkg::LANES]
);

    fft_pkg::tw_addr_t addr [fft_pkg::LANES];

    // Packed {re, im}: round(128*cos), round(-128*sin) of 2*pi*k/64
    function automatic logic [2*$bits(fft_pkg::twf_t)-1:0] tw_entry(
        input fft_pkg::tw_addr_t k
    );
        case (k)
            5'd0:  tw_entry = {9'sd128,   9'sd0};
            5'd1:  tw_entry = {9'sd127,  -9'sd13};
            5'd2:  tw_entry = {9'sd126,  -9'sd25};
            5'd3:  tw_entry = {9'sd122,  -9'sd37};
            5'd4:  tw_entry = {9'sd118,  -9'sd49};
            5'd5:  tw_entry = {9'sd113,  -9'sd60};
            5'd6:  tw_entry = {9'sd106,  -9'sd71};
            5'd7:  tw_entry = {9'sd99,   -9'sd81};
            5'd8:  tw_entry = {9'sd91,   -9'sd91};
            5'd9:  tw_entry = {9'sd81,   -9'sd99};
            5'd10: tw_entry = {9'sd71,   -9'sd106};
            5'd11: tw_entry = {9'sd60,   -9'sd113};
            5'd12: tw_entry = {9'sd49,   -9'sd118};
            5'd13: tw_entry = {9'sd37,   -9'sd122};
            5'd14: tw_entry = {9'sd25,   -9'sd126};
            5'd15: tw_entry = {9'sd13,   -9'sd127};
            5'd16: tw_entry = {9'sd0,    -9'sd128};
            5'd17: tw_entry = {-9'sd13,  -9'sd127};
            5'd18: tw_entry = {-9'sd25,  -9'sd126};
            5'd19: tw_entry = {-9'sd37,  -9'sd122};
            5'd20: tw_entry = {-9'sd49,  -9'sd118};
            5'd21: tw_entry = {-9'sd60,  -9'sd113};
            5'd22: tw_entry = {-9'sd71,  -9'sd106};
            5'd23: tw_entry = {-9'sd81,  -9'sd99};
            5'd24: tw_entry = {-9'sd91,  -9'sd91};
            5'd25: tw_entry = {-9'sd99,  -9'sd81};
            5'd26: tw_entry = {-9'sd106, -9'sd71};
            5'd27: tw_entry = {-9'sd113, -9'sd60};
            5'd28: tw_entry = {-9'sd118, -9'sd49};
            5'd29: tw_entry = {-9'sd122, -9'sd37};
            5'd30: tw_entry = {-9'sd126, -9'sd25};
            default: tw_entry = {-9'sd127, -9'sd13};
        endcase
    endfunction

    // One table row per lane of the block
    always_comb begin
        for (int l = 0; l < fft_pkg::LANES; l++) begin
            addr[l] = fft_pkg::tw_addr_t'(int'(blk) * fft_pkg::LANES + l);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int l = 0; l < fft_pkg::LANES; l++) begin
                tw_re[l] <= '0;
                tw_im[l] <= '0;
            end
        end else begin
            for (int l = 0; l < fft_pkg::LANES; l++) begin
                {tw_re[l], tw_im[l]} <= tw_entry(addr[l]);
            end
        end
    end

endmodule

// ==== source/bfly_if.sv ====
// Sample pairs from the input buffer to the butterfly
interface pair_if;
    logic             valid;
    fft_pkg::sample_t a_re [fft_pkg::LANES];
    fft_pkg::sample_t a_im [fft_pkg::LANES];
    fft_pkg::sample_t b_re [fft_pkg::LANES];
    fft_pkg::sample_t b_im [fft_pkg::LANES];

    modport src (output valid, a_re, a_im, b_re, b_im);
    modport snk (input  valid, a_re, a_im, b_re, b_im);
endinterface

// Twiddled results from the butterfly to the output queue
interface res_if;
    logic           valid;
    fft_pkg::prod_t add_re  [fft_pkg::LANES];
    fft_pkg::prod_t add_im  [fft_pkg::LANES];
    fft_pkg::prod_t diff_re [fft_pkg::LANES];
    fft_pkg::prod_t diff_im [fft_pkg::LANES];

    modport src (output valid, add_re, add_im, diff_re, diff_im);
    modport snk (input  valid, add_re, add_im, diff_re, diff_im);
endinterface

// ==== source/fft_pkg.sv ====
package fft_pkg;

    // Block geometry
    localparam int LANES     = 4;
    localparam int BLOCKS    = 8;
    localparam int TW_DEPTH  = LANES * BLOCKS;

    // Queue depths, in blocks
    localparam int IN_DEPTH  = 4;
    localparam int OUT_DEPTH = 4;

    // Derived address widths
    localparam int TW_AW     = $clog2(TW_DEPTH);
    localparam int IN_PW     = $clog2(IN_DEPTH);
    localparam int OUT_PW    = $clog2(OUT_DEPTH);

    // Input sample component
    typedef logic signed [12:0] sample_t;

    // a+b or a-b, one bit of growth
    typedef logic signed [13:0] bsum_t;

    // Twiddle component in Q1.7
    typedef logic signed [8:0]  twf_t;

    // Full precision product
    typedef logic signed [22:0] prod_t;

    typedef logic [2:0]         blk_idx_t;
    typedef logic [TW_AW-1:0]   tw_addr_t;
    typedef logic [2:0]         credit_cnt_t;

endpackage
